/* compile.f */
+incdir+source
source/icache_pkg.sv
source/icache_array_if.sv
source/icache_ram.sv
source/icache_victim.sv
source/icache_ways.sv
source/icache_ctrl.sv
source/icache_top.sv
bench/icache_properties.sv
bench/icache_tb.sv

/* Bender.yml */
package:
  name: icache

sources:
  # cache RTL
  - include_dirs:
      - source
    files:
      - source/icache_pkg.sv
      - source/icache_array_if.sv
      - source/icache_ram.sv
      - source/icache_victim.sv
      - source/icache_ways.sv
      - source/icache_ctrl.sv
      - source/icache_top.sv
  # testbench and bound assertions
  - target: test
    include_dirs:
      - source
    files:
      - bench/icache_properties.sv
      - bench/icache_tb.sv

/* bench/icache_tb.sv */
/*
 * instruction cache testbench with memory model, stimulus table and result checks
 */
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_tb;
  import icache_pkg::*;

  localparam int    CLK_PERIOD = 100;
  localparam int    WAIT_LIMIT = 200;
  localparam addr_t LINE_MASK  = ~addr_t'((1 << (`ICACHE_OFFSET_W + `ICACHE_BEAT_IDX_W)) - 1);
  localparam addr_t BEAT_MASK  = ~addr_t'((1 << `ICACHE_OFFSET_W) - 1);

  // flush rows ignore the address
  typedef struct {
    addr_t addr;
    logic  flush;
    word_t word;
    logic  miss;
  } row_t;

  logic  clk_i, rst_i, flush_i, flush_done_o, cache_miss_o;
  logic  fetch_req_i, fetch_ready_o, fetch_valid_o;
  addr_t fetch_addr_i, mem_req_addr_o;
  word_t fetch_data_o;
  logic  mem_req_valid_o, mem_req_ready_i, mem_req_single_o;
  logic  mem_rsp_valid_i, mem_rsp_ready_o;
  beat_t mem_rsp_data_i;

  // memory model bookkeeping
  int     req_count  = 0;
  int     miss_count = 0;
  int     beats_left = 0;
  addr_t  last_addr  = '0;
  addr_t  beat_addr  = '0;
  logic   last_single = 1'b0;
  logic   gaps = 1'b0;
  integer seed = 32'h3a8e_5bdc;
  row_t   rows[$];

  icache_top dut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // memory word at byte address a
  function automatic word_t pattern(input addr_t a);
    return word_t'({a[`ICACHE_ADDR_W-1:2], 2'b00}) ^ 32'h5a5a_0000;
  endfunction

  // ========================================
  // memory model
  // ========================================
  initial begin : memory_model
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_data_i  = '0;
    forever begin
      @(negedge clk_i);
      // random gaps only in the second pass
      mem_req_ready_i = !gaps || (($random(seed) & 3) != 0);
      mem_rsp_valid_i = (beats_left > 0) && (!gaps || (($random(seed) & 3) != 0));
      mem_rsp_data_i  = {pattern(beat_addr + 4), pattern(beat_addr)};
      @(posedge clk_i);
      if (cache_miss_o) miss_count++;
      if (mem_req_valid_o && mem_req_ready_i) begin
        req_count++;
        last_addr   = mem_req_addr_o;
        last_single = mem_req_single_o;
        beat_addr   = mem_req_addr_o;
        beats_left  = mem_req_single_o ? 1 : `ICACHE_BEATS;
      end
      if (mem_rsp_valid_i && mem_rsp_ready_o) begin
        beat_addr = beat_addr + 8;
        beats_left--;
      end
    end
  end

  // ========================================
  // checks
  // ========================================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      abort_run($sformatf("FAIL %0t %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  // bound handshake assertion failure ends the run at once
  always @(dut.u_props.fail_count) begin
    if (dut.u_props.fail_count != 0) begin
      abort_run("a handshake assertion on the cache top level failed");
    end
  end

  // ========================================
  // stimulus
  // ========================================
  task automatic add_row(input addr_t addr, input logic flush, input logic miss);
    row_t r;
    r.addr  = addr;
    r.flush = flush;
    r.word  = pattern(addr);
    r.miss  = miss;
    rows.push_back(r);
  endtask

  // one cycle of flush_i while idle
  task automatic run_flush();
    flush_i = 1'b1;
    @(posedge clk_i);
    check_flag("flush_done_o", flush_done_o, 1'b1);
    check_flag("fetch_ready_o", fetch_ready_o, 1'b0);
    @(negedge clk_i);
    flush_i = 1'b0;
    @(posedge clk_i);
    check_flag("flush_done_o", flush_done_o, 1'b0);
    @(negedge clk_i);
  endtask

  // starts and ends on a falling edge
  task automatic run_fetch(input row_t r);
    int   req_base;
    int   miss_base;
    int   cycles;
    logic cached;
    req_base     = req_count;
    miss_base    = miss_count;
    cached       = !r.addr[`ICACHE_UNCACHED_BIT];
    fetch_addr_i = r.addr;
    fetch_req_i  = 1'b1;
    cycles       = 0;
    do begin
      @(posedge clk_i);
      cycles++;
    end while (!fetch_ready_o && cycles < WAIT_LIMIT);
    if (!fetch_ready_o) abort_run("timeout waiting for fetch_ready_o to accept a fetch");
    @(negedge clk_i);
    fetch_req_i = 1'b0;
    cycles      = 0;
    do begin
      @(posedge clk_i);
      cycles++;
    end while (!fetch_valid_o && cycles < WAIT_LIMIT);
    if (!fetch_valid_o) abort_run("timeout waiting for fetch_valid_o after a fetch");
    check_word("fetch_data_o", fetch_data_o, r.word);
    @(negedge clk_i);
    check_count("refill requests", req_count - req_base, (r.miss || !cached) ? 1 : 0);
    check_count("cache_miss_o pulses", miss_count - miss_base, r.miss ? 1 : 0);
    if (r.miss || !cached) begin
      check_addr("mem_req_addr_o", last_addr,
                 cached ? (r.addr & LINE_MASK) : (r.addr & BEAT_MASK));
      check_flag("mem_req_single_o", last_single, !cached);
    end else begin
      // hit answers one cycle after acceptance
      check_count("hit latency", cycles, 1);
    end
  endtask

  initial begin : stimulus
    rst_i        = 1'b0;
    flush_i      = 1'b0;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    // empty cache at the start of each pass
    add_row('0, 1'b1, 1'b0);
    // cold miss then hits in the same line
    add_row(32'h0000_0104, 1'b0, 1'b1);
    add_row(32'h0000_0108, 1'b0, 1'b0);
    add_row(32'h0000_011c, 1'b0, 1'b0);
    // lines A to E all map to set 3 and E replaces B
    add_row(32'h0000_1060, 1'b0, 1'b1);
    add_row(32'h0000_1264, 1'b0, 1'b1);
    add_row(32'h0000_1468, 1'b0, 1'b1);
    add_row(32'h0000_166c, 1'b0, 1'b1);
    add_row(32'h0000_1070, 1'b0, 1'b0);
    add_row(32'h0000_1874, 1'b0, 1'b1);
    add_row(32'h0000_1060, 1'b0, 1'b0);
    add_row(32'h0000_1460, 1'b0, 1'b0);
    add_row(32'h0000_1660, 1'b0, 1'b0);
    add_row(32'h0000_1260, 1'b0, 1'b1);
    // line that hit before misses after flush
    add_row('0, 1'b1, 1'b0);
    add_row(32'h0000_0104, 1'b0, 1'b1);
    // io space reads of the upper and lower half of a beat
    add_row(32'h8000_0204, 1'b0, 1'b0);
    add_row(32'h8000_0204, 1'b0, 1'b0);
    add_row(32'h8000_0200, 1'b0, 1'b0);
    repeat (10) @(negedge clk_i);
    rst_i = 1'b1;
    @(posedge clk_i);
    check_flag("fetch_ready_o", fetch_ready_o, 1'b1);
    check_flag("fetch_valid_o", fetch_valid_o, 1'b0);
    check_flag("mem_req_valid_o", mem_req_valid_o, 1'b0);
    check_flag("mem_rsp_ready_o", mem_rsp_ready_o, 1'b0);
    check_flag("flush_done_o", flush_done_o, 1'b0);
    check_flag("cache_miss_o", cache_miss_o, 1'b0);
    @(negedge clk_i);
    for (int pass = 0; pass < 2; pass++) begin
      foreach (rows[i]) begin
        if (rows[i].flush) run_flush();
        else run_fetch(rows[i]);
      end
      // second pass with memory back-pressure
      @(posedge clk_i);
      gaps = 1'b1;
      @(negedge clk_i);
    end
    $display("Regression passed");
    $finish;
  end
endmodule

/* bench/icache_properties.sv */
/*
 * handshake assertions for the instruction cache top level
 */
`timescale 1ns/1ps

module icache_properties (
  input logic              clk_i,
  input logic              rst_i,
  input logic              flush_i,
  input logic              flush_done_o,
  input logic              fetch_ready_o,
  input logic              fetch_valid_o,
  input logic              mem_req_valid_o,
  input logic              mem_req_ready_i,
  input logic              mem_req_single_o,
  input icache_pkg::addr_t mem_req_addr_o
);
  // failures seen so far
  int fail_count = 0;

  // request held until taken
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_i)
    mem_req_valid_o && !mem_req_ready_i |=>
      mem_req_valid_o && $stable(mem_req_addr_o) && $stable(mem_req_single_o))
    else begin
      $error("refill request changed before mem_req_ready_i");
      fail_count++;
    end

  // done pulse only while flush is requested
  flush_pair: assert property (@(posedge clk_i) disable iff (!rst_i)
    flush_done_o |-> flush_i)
    else begin
      $error("flush_done_o high without flush_i");
      fail_count++;
    end

  // fetch side quiet while a refill request waits
  req_quiet: assert property (@(posedge clk_i) disable iff (!rst_i)
    mem_req_valid_o |-> !fetch_valid_o && !fetch_ready_o)
    else begin
      $error("fetch handshake active during refill request");
      fail_count++;
    end
endmodule

bind icache_top icache_properties u_props (.*);

/* source/icache_top.sv */
/*
 * four-way set-associative instruction cache, top level
 */
`timescale 1ns/1ps

module icache_top (
  input  logic              clk_i,
  input  logic              rst_i,
  // maintenance and events
  input  logic              flush_i,
  output logic              flush_done_o,
  output logic              cache_miss_o,
  // fetch port
  input  logic              fetch_req_i,
  input  icache_pkg::addr_t fetch_addr_i,
  output logic              fetch_ready_o,
  output logic              fetch_valid_o,
  output icache_pkg::word_t fetch_data_o,
  // refill request channel
  output logic              mem_req_valid_o,
  input  logic              mem_req_ready_i,
  output icache_pkg::addr_t mem_req_addr_o,
  output logic              mem_req_single_o,
  // refill response channel
  input  logic              mem_rsp_valid_i,
  output logic              mem_rsp_ready_o,
  input  icache_pkg::beat_t mem_rsp_data_i
);

  // controller to way storage
  icache_array_if arr ();

  icache_ctrl u_ctrl (
    .clk_i, .rst_i,
    .flush_i, .flush_done_o, .cache_miss_o,
    .fetch_req_i, .fetch_addr_i, .fetch_ready_o, .fetch_valid_o, .fetch_data_o,
    .mem_req_valid_o, .mem_req_ready_i, .mem_req_addr_o, .mem_req_single_o,
    .mem_rsp_valid_i, .mem_rsp_ready_o, .mem_rsp_data_i,
    .arr(arr.ctrl)
  );

  // tags, valid bits, data and replacement
  icache_ways u_ways (
    .clk_i,
    .rst_i,
    .flush_i,
    .arr(arr.arrays)
  );
endmodule

/* source/icache_ctrl.sv */
/*
 * icache controller: fetch handshake, lookup, line refill and uncacheable reads
 */
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_ctrl (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              flush_i,
  output logic              flush_done_o,
  output logic              cache_miss_o,
  input  logic              fetch_req_i,
  input  icache_pkg::addr_t fetch_addr_i,
  output logic              fetch_ready_o,
  output logic              fetch_valid_o,
  output icache_pkg::word_t fetch_data_o,
  output logic              mem_req_valid_o,
  input  logic              mem_req_ready_i,
  output icache_pkg::addr_t mem_req_addr_o,
  output logic              mem_req_single_o,
  input  logic              mem_rsp_valid_i,
  output logic              mem_rsp_ready_o,
  input  icache_pkg::beat_t mem_rsp_data_i,
  icache_array_if.ctrl      arr
);
  import icache_pkg::*;

  localparam int LINE_OFF_W = `ICACHE_OFFSET_W + `ICACHE_BEAT_IDX_W;
  localparam int CNT_W      = `ICACHE_BEAT_IDX_W + 1;

  typedef enum logic [1:0] {IDLE, LOOKUP, REFILL, UNCACHED} state_e;

  state_e           state_q, state_d;
  logic [CNT_W-1:0] cnt_q, cnt_d;
  addr_t            addr_q;
  logic             accept;
  logic             uncached;

  // ========================================
  // address and datapath
  // ========================================
  assign uncached         = addr_q[`ICACHE_UNCACHED_BIT];
  assign mem_req_single_o = uncached;
  // line aligned for refills, beat aligned for io reads
  assign mem_req_addr_o = uncached ?
    {addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}} :
    {addr_q[`ICACHE_ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};

  // re-read uses the held address
  assign arr.rd_addr = (state_q == REFILL) ? addr_q : fetch_addr_i;
  assign arr.wr_data = mem_rsp_data_i;
  // beats come in address order, counter runs down
  assign arr.wr_beat = beat_idx_t'(`ICACHE_BEATS - cnt_q);

  // io word straight from the beat
  assign fetch_data_o = (state_q == UNCACHED) ?
    mem_rsp_data_i[addr_q[`ICACHE_OFFSET_W-1] * `ICACHE_WORD_W +: `ICACHE_WORD_W] :
    arr.hit_word;

  // ========================================
  // state machine
  // ========================================
  always_comb begin
    state_d = state_q;
    cnt_d = cnt_q;
    accept = 1'b0;
    arr.rd_en = 1'b0;
    arr.data_we = 1'b0;
    arr.tag_we = 1'b0;
    arr.hit_ack = 1'b0;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    mem_req_valid_o = 1'b0;
    mem_rsp_ready_o = 1'b0;
    flush_done_o = 1'b0;
    cache_miss_o = 1'b0;
    unique case (state_q)
      IDLE: begin
        // flush wins over a fetch
        flush_done_o  = flush_i;
        fetch_ready_o = !flush_i;
        accept        = fetch_req_i && !flush_i;
      end
      LOOKUP: begin
        if (!uncached && arr.hit) begin
          fetch_valid_o = 1'b1;
          fetch_ready_o = 1'b1;
          arr.hit_ack   = 1'b1;
          accept        = fetch_req_i;
          state_d       = IDLE;
        end else begin
          // miss or io, hold request until taken
          mem_req_valid_o = 1'b1;
          if (mem_req_ready_i) begin
            cache_miss_o = !uncached;
            cnt_d        = CNT_W'(`ICACHE_BEATS);
            state_d      = uncached ? UNCACHED : REFILL;
          end
        end
      end
      REFILL: begin
        if (cnt_q != '0) begin
          mem_rsp_ready_o = 1'b1;
          if (mem_rsp_valid_i) begin
            arr.data_we = 1'b1;
            // tag goes in with the last beat
            arr.tag_we  = (cnt_q == CNT_W'(1));
            cnt_d       = cnt_q - 1'b1;
          end
        end else begin
          arr.rd_en = 1'b1;
          state_d   = LOOKUP;
        end
      end
      UNCACHED: begin
        mem_rsp_ready_o = 1'b1;
        if (mem_rsp_valid_i) begin
          fetch_valid_o = 1'b1;
          state_d       = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
    if (accept) begin
      arr.rd_en = 1'b1;
      state_d   = LOOKUP;
    end
  end

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // accepted fetch address
  always_ff @(posedge clk_i) begin
    if (accept) addr_q <= fetch_addr_i;
  end
endmodule

/* source/icache_ways.sv */
/*
 * tag, valid and data storage of all ways, with tag compare and word select
 */
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_ways (
  input logic            clk_i,
  input logic            rst_i,
  input logic            flush_i,
  icache_array_if.arrays arr
);
  import icache_pkg::*;

  localparam int LINE_OFF_W = `ICACHE_OFFSET_W + `ICACHE_BEAT_IDX_W;
  localparam int DATA_IDX_W = `ICACHE_BEAT_IDX_W + `ICACHE_SET_W;

  // ========================================
  // lookup address registers
  // ========================================
  way_vec_t [`ICACHE_SETS-1:0] valid_q;
  set_idx_t set_q;
  tag_t     tag_q;
  logic     half_q;
  logic     rd_q;
  way_idx_t victim_q;
  way_idx_t victim;
  way_idx_t hit_way;
  way_vec_t hit_vec;
  tag_t     rd_tag  [`ICACHE_WAYS];
  beat_t    rd_beat [`ICACHE_WAYS];

  // set, tag and word half of the address that was read
  always_ff @(posedge clk_i) begin
    if (arr.rd_en) begin
      set_q  <= arr.rd_addr[LINE_OFF_W +: `ICACHE_SET_W];
      tag_q  <= arr.rd_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
      half_q <= arr.rd_addr[`ICACHE_OFFSET_W-1];
    end
  end

  // valid bits, flush clears all sets at once
  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (arr.tag_we) begin
      valid_q[set_q][victim_q] <= 1'b1;
    end
  end

  // victim sampled in the lookup cycle, steady through the refill
  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      rd_q     <= 1'b0;
      victim_q <= '0;
    end else begin
      rd_q <= arr.rd_en;
      if (rd_q) victim_q <= victim;
    end
  end

  // ========================================
  // per-way storage and compare
  // ========================================
  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    icache_ram #(.item_t(tag_t), .DEPTH(`ICACHE_SETS)) u_tag (
      .clk_i, .rd_en_i(arr.rd_en),
      .rd_idx_i(arr.rd_addr[LINE_OFF_W +: `ICACHE_SET_W]), .wr_idx_i(set_q),
      .we_i(arr.tag_we && (victim_q == w)), .wdata_i(tag_q), .rdata_o(rd_tag[w])
    );
    icache_ram #(.item_t(beat_t), .DEPTH(`ICACHE_SETS * `ICACHE_BEATS)) u_data (
      .clk_i, .rd_en_i(arr.rd_en),
      .rd_idx_i(arr.rd_addr[`ICACHE_OFFSET_W +: DATA_IDX_W]), .wr_idx_i({set_q, arr.wr_beat}),
      .we_i(arr.data_we && (victim_q == w)), .wdata_i(arr.wr_data), .rdata_o(rd_beat[w])
    );
    assign hit_vec[w] = valid_q[set_q][w] && (rd_tag[w] == tag_q);
  end

  // at most one way hits
  always_comb begin
    hit_way = '0;
    for (int i = 0; i < `ICACHE_WAYS; i++) begin
      if (hit_vec[i]) hit_way = way_idx_t'(i);
    end
  end

  assign arr.hit      = |hit_vec;
  assign arr.hit_word = rd_beat[hit_way][half_q * `ICACHE_WORD_W +: `ICACHE_WORD_W];

  icache_victim u_victim (
    .clk_i, .rst_i,
    .set_i(set_q), .hit_i(arr.hit_ack), .hit_way_i(hit_way),
    .valid_i(valid_q[set_q]), .victim_o(victim)
  );
endmodule

/* source/icache_victim.sv */
/*
 * victim way choice: lowest invalid way, else per-set tree pseudo-LRU
 */
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_victim (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  icache_pkg::set_idx_t set_i,
  input  logic                 hit_i,
  input  icache_pkg::way_idx_t hit_way_i,
  input  icache_pkg::way_vec_t valid_i,
  output icache_pkg::way_idx_t victim_o
);
  import icache_pkg::*;

  // bit 0 picks odd or even ways, bits 1 and 2 pick within even and odd pair
  logic [`ICACHE_SETS-1:0][2:0] tree_q;
  way_idx_t tree_way;
  way_idx_t inv_way;

  // point every level away from the way just used
  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      tree_q <= '0;
    end else if (hit_i) begin
      tree_q[set_i][0] <= ~hit_way_i[0];
      tree_q[set_i][1 + hit_way_i[0]] <= ~hit_way_i[1];
    end
  end

  // walk the tree
  assign tree_way[0] = tree_q[set_i][0];
  assign tree_way[1] = tree_q[set_i][1 + tree_way[0]];

  // lowest-numbered invalid way wins
  always_comb begin
    inv_way = '0;
    for (int i = `ICACHE_WAYS - 1; i >= 0; i--) begin
      if (!valid_i[i]) inv_way = way_idx_t'(i);
    end
  end

  assign victim_o = (&valid_i) ? tree_way : inv_way;
endmodule

/* source/icache_ram.sv */
/*
 * single-port storage with registered read, used for tags and line data
 */
`timescale 1ns/1ps

module icache_ram #(
  parameter type item_t = logic [7:0],
  parameter int  DEPTH  = 16
) (
  input  logic                     clk_i,
  input  logic                     rd_en_i,
  input  logic [$clog2(DEPTH)-1:0] rd_idx_i,
  input  logic [$clog2(DEPTH)-1:0] wr_idx_i,
  input  logic                     we_i,
  input  item_t                    wdata_i,
  output item_t                    rdata_o
);

  item_t mem [DEPTH];

  // write port
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[wr_idx_i] <= wdata_i;
    end
  end

  // output holds until the next read
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rdata_o <= mem[rd_idx_i];
    end
  end
endmodule

/* source/icache_array_if.sv */
/*
 * icache array link between the fetch controller and the way storage
 */
`timescale 1ns/1ps

interface icache_array_if;
  import icache_pkg::*;

  // lookup side
  logic      rd_en;
  addr_t     rd_addr;
  logic      hit_ack;
  logic      hit;
  word_t     hit_word;
  // refill write side
  logic      data_we;
  logic      tag_we;
  beat_idx_t wr_beat;
  beat_t     wr_data;

  modport ctrl (
    output rd_en, rd_addr, data_we, tag_we, wr_beat, wr_data, hit_ack,
    input  hit, hit_word
  );

  modport arrays (
    input  rd_en, rd_addr, data_we, tag_we, wr_beat, wr_data, hit_ack,
    output hit, hit_word
  );
endinterface

/* source/icache_pkg.sv */
/*
 * instruction cache shared types
 */
`include "icache_cfg.svh"

package icache_pkg;

  // physical fetch and refill address
  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

  // address fields
  typedef logic [`ICACHE_TAG_W-1:0] tag_t;
  typedef logic [`ICACHE_SET_W-1:0] set_idx_t;
  typedef logic [`ICACHE_BEAT_IDX_W-1:0] beat_idx_t;

  // way numbering
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_idx_t;
  // one flag per way
  typedef logic [`ICACHE_WAYS-1:0] way_vec_t;

  // payloads
  typedef logic [`ICACHE_BEAT_W-1:0] beat_t;
  typedef logic [`ICACHE_WORD_W-1:0] word_t;

endpackage

/* source/icache_cfg.svh */
/*
 * instruction cache geometry and address field widths
 */
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// base geometry
`define ICACHE_ADDR_W        32
`define ICACHE_WAYS          4
`define ICACHE_SETS          16
`define ICACHE_BEATS         4
`define ICACHE_BEAT_W        64
`define ICACHE_WORD_W        32
// bit 31 set marks io space
`define ICACHE_UNCACHED_BIT  31

// derived field widths
`define ICACHE_OFFSET_W      3
`define ICACHE_BEAT_IDX_W    2
`define ICACHE_SET_W         4
`define ICACHE_TAG_W         23

`endif
